//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module lsu_tb

run: build
	./obj_dir/Vlsu_tb | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timing -f vlog.f --top-module lsu_tb

clean:
	rm -rf obj_dir $(LOG)

//--- src/agu_issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module agu_issue_queue (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             issue_valid,
    output logic                  issue_ready,
    input  wire lsu_pkg::mem_op_t issue_op,
    input  wire lsu_pkg::word_t   issue_base,
    input  wire logic [15:0]      issue_offset,
    input  wire lsu_pkg::word_t   issue_value,
    input  wire lsu_pkg::tag_t    issue_tag,
    output logic                  entry_valid,
    output lsu_pkg::mem_req_t     entry,
    input  wire logic             load_accept,
    input  wire logic             store_accept
);

    lsu_pkg::mem_req_t slot [2];
    logic [1:0] slot_valid;
    logic       head;
    logic       tail;
    logic       started;
    logic       push;
    logic       pop;

    // held off for the first cycle out of reset
    assign issue_ready = started && (slot_valid != 2'b11);

    assign entry_valid = slot_valid[head];
    assign entry       = slot[head];

    assign push = issue_valid && issue_ready;
    // only the consumer that owns this op may pop it
    assign pop  = entry_valid && (lsu_pkg::is_store(entry.op) ? store_accept : load_accept);

    always_ff @(posedge clk) begin
        if (reset) begin
            started    <= 1'b0;
            slot_valid <= 2'b00;
            head       <= 1'b0;
            tail       <= 1'b0;
        end else begin
            started <= 1'b1;
            // push and pop never hit the same slot
            if (pop) begin
                slot_valid[head] <= 1'b0;
                head             <= !head;
            end
            if (push) begin
                slot_valid[tail] <= 1'b1;
                tail             <= !tail;
            end
        end
    end

    // address is final once written
    always_ff @(posedge clk) begin
        if (push) begin
            slot[tail] <= '{
                op:    issue_op,
                addr:  issue_base + {{16{issue_offset[15]}}, issue_offset},
                value: issue_value,
                tag:   issue_tag
            };
        end
    end

endmodule

`default_nettype wire

//--- src/dbus_if.sv
`timescale 1ns/10ps
`default_nettype none

// one data-cache request channel
interface dbus_if;

    logic            req;
    logic            wr;
    lsu_pkg::strb_t  wstrb;
    lsu_pkg::size_t  size;
    lsu_pkg::word_t  addr;
    lsu_pkg::word_t  wdata;
    logic            addr_ok;
    logic            data_ok;
    lsu_pkg::word_t  rdata;

    // request fields stay put from req until addr_ok
    modport requester (
        output req, wr, wstrb, size, addr, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport arbiter (
        input  req, wr, wstrb, size, addr, wdata,
        output addr_ok, data_ok, rdata
    );

endinterface

`default_nettype wire

//--- src/dcache_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_arbiter (
    input  wire logic            clk,
    input  wire logic            reset,
    dbus_if.arbiter              load_bus,
    dbus_if.arbiter              store_bus,
    output logic                 dcache_req,
    output logic                 dcache_wr,
    output lsu_pkg::strb_t       dcache_wstrb,
    output lsu_pkg::size_t       dcache_size,
    output lsu_pkg::word_t       dcache_addr,
    output lsu_pkg::word_t       dcache_wdata,
    input  wire logic            dcache_addr_ok,
    input  wire logic            dcache_data_ok,
    input  wire lsu_pkg::word_t  dcache_rdata
);

    logic busy;
    logic owner_store;
    logic pick_store;

    // loads win while idle, owner sticks until data_ok
    assign pick_store = busy ? owner_store : !load_bus.req;

    assign dcache_req   = !busy && (load_bus.req || store_bus.req);
    assign dcache_wr    = pick_store ? store_bus.wr    : load_bus.wr;
    assign dcache_wstrb = pick_store ? store_bus.wstrb : load_bus.wstrb;
    assign dcache_size  = pick_store ? store_bus.size  : load_bus.size;
    assign dcache_addr  = pick_store ? store_bus.addr  : load_bus.addr;
    assign dcache_wdata = pick_store ? store_bus.wdata : load_bus.wdata;

    assign load_bus.addr_ok  = dcache_req && dcache_addr_ok && !pick_store;
    assign store_bus.addr_ok = dcache_req && dcache_addr_ok && pick_store;
    assign load_bus.data_ok  = busy && dcache_data_ok && !owner_store;
    assign store_bus.data_ok = busy && dcache_data_ok && owner_store;
    assign load_bus.rdata    = dcache_rdata;
    assign store_bus.rdata   = dcache_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            owner_store <= 1'b0;
        end else if (dcache_req && dcache_addr_ok) begin
            busy        <= 1'b1;
            owner_store <= pick_store;
        end else if (dcache_data_ok) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/load_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_unit (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              entry_valid,
    input  wire lsu_pkg::mem_req_t entry,
    output logic                   load_accept,
    output logic                   load_valid,
    input  wire logic              load_ready,
    output lsu_pkg::tag_t          load_tag,
    output lsu_pkg::word_t         load_result,
    output lsu_pkg::exc_t          load_exc,
    output lsu_pkg::word_t         load_badvaddr,
    dbus_if.requester              bus
);

    // request stage
    lsu_pkg::mem_req_t req_entry;
    logic              req_valid;
    logic              req_fault;
    logic              req_go;

    // response stage
    logic              resp_valid;
    logic              resp_done;
    logic              resp_free;
    logic              resp_take;
    lsu_pkg::mem_op_t  resp_op;
    lsu_pkg::word_t    resp_addr;
    lsu_pkg::word_t    resp_result;
    lsu_pkg::tag_t     resp_tag;
    lsu_pkg::exc_t     resp_exc;

    function automatic lsu_pkg::word_t extract(lsu_pkg::mem_op_t op, logic [1:0] low,
                                               lsu_pkg::word_t data);
        logic [7:0]  b;
        logic [15:0] h;
        b = data[{low, 3'b000} +: 8];
        h = low[1] ? data[31:16] : data[15:0];
        case (op)
            lsu_pkg::LB:  return {{24{b[7]}}, b};
            lsu_pkg::LBU: return {24'h0, b};
            lsu_pkg::LH:  return {{16{h[15]}}, h};
            lsu_pkg::LHU: return {16'h0, h};
            default:      return data;
        endcase
    endfunction

    assign req_fault = lsu_pkg::misaligned(req_entry.op, req_entry.addr[1:0]);
    assign resp_free = !resp_valid || (resp_done && load_ready);
    // a faulting load skips the cache
    assign req_go    = req_valid && resp_free && (req_fault || bus.addr_ok);
    assign resp_take = resp_valid && !resp_done && bus.data_ok;

    assign load_accept = entry_valid && !lsu_pkg::is_store(entry.op) && (!req_valid || req_go);

    // req only raised once the response stage can take it, so it never drops early
    assign bus.req   = req_valid && !req_fault && resp_free;
    assign bus.wr    = 1'b0;
    assign bus.wstrb = 4'h0;
    assign bus.size  = lsu_pkg::access_size(req_entry.op);
    assign bus.addr  = req_entry.addr;
    assign bus.wdata = 32'h0;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid  <= 1'b0;
            resp_valid <= 1'b0;
            resp_done  <= 1'b0;
        end else begin
            if (load_accept) begin
                req_valid <= 1'b1;
            end else if (req_go) begin
                req_valid <= 1'b0;
            end

            if (req_go) begin
                resp_valid <= 1'b1;
                resp_done  <= req_fault;
            end else if (resp_take) begin
                resp_done <= 1'b1;
            end else if (load_valid && load_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_accept) begin
            req_entry <= entry;
        end
        if (req_go) begin
            resp_op     <= req_entry.op;
            resp_addr   <= req_entry.addr;
            resp_tag    <= req_entry.tag;
            resp_exc    <= req_fault ? lsu_pkg::EXC_ADEL : lsu_pkg::EXC_NONE;
            resp_result <= 32'h0;
        end else if (resp_take) begin
            resp_result <= extract(resp_op, resp_addr[1:0], bus.rdata);
        end
    end

    assign load_valid    = resp_valid && resp_done;
    assign load_tag      = resp_tag;
    assign load_result   = resp_result;
    assign load_exc      = resp_exc;
    assign load_badvaddr = resp_addr;

endmodule

`default_nettype wire

//--- src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int TAG_W = 4;
    localparam int SB_DEPTH = 4;
    localparam int SB_PTR_W = 2;

    typedef logic [31:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [3:0] strb_t;
    typedef logic [2:0] size_t;

    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } mem_op_t;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADEL,
        EXC_ADES
    } exc_t;

    // entry handed from the issue queue to load unit and store buffer
    typedef struct packed {
        mem_op_t op;
        word_t   addr;
        word_t   value;
        tag_t    tag;
    } mem_req_t;

    function automatic logic is_store(mem_op_t op);
        return op == SB || op == SH || op == SW;
    endfunction

    // halfwords need bit 0 clear, words both low bits
    function automatic logic misaligned(mem_op_t op, logic [1:0] low);
        case (op)
            LH, LHU, SH: return low[0];
            LW, SW: return low != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    function automatic size_t access_size(mem_op_t op);
        case (op)
            LB, LBU, SB: return SIZE_BYTE;
            LH, LHU, SH: return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  wire logic             clk,
    input  wire logic             reset,

    input  wire logic             issue_valid,
    output logic                  issue_ready,
    input  wire lsu_pkg::mem_op_t issue_op,
    input  wire lsu_pkg::word_t   issue_base,
    input  wire logic [15:0]      issue_offset,
    input  wire lsu_pkg::word_t   issue_value,
    input  wire lsu_pkg::tag_t    issue_tag,

    output logic                  load_valid,
    input  wire logic             load_ready,
    output lsu_pkg::tag_t         load_tag,
    output lsu_pkg::word_t        load_result,
    output lsu_pkg::exc_t         load_exc,
    output lsu_pkg::word_t        load_badvaddr,

    output logic                  store_valid,
    output lsu_pkg::tag_t         store_tag,
    output lsu_pkg::exc_t         store_exc,
    output lsu_pkg::word_t        store_badvaddr,
    input  wire logic             commit_store,

    output logic                  dcache_req,
    output logic                  dcache_wr,
    output lsu_pkg::strb_t        dcache_wstrb,
    output lsu_pkg::size_t        dcache_size,
    output lsu_pkg::word_t        dcache_addr,
    output lsu_pkg::word_t        dcache_wdata,
    input  wire logic             dcache_addr_ok,
    input  wire logic             dcache_data_ok,
    input  wire lsu_pkg::word_t   dcache_rdata
);

    logic              entry_valid;
    lsu_pkg::mem_req_t entry;
    logic              load_accept;
    logic              store_accept;

    dbus_if load_bus ();
    dbus_if store_bus ();

    agu_issue_queue agu_issue_queue_inst (
        .clk, .reset,
        .issue_valid, .issue_ready, .issue_op, .issue_base, .issue_offset,
        .issue_value, .issue_tag,
        .entry_valid, .entry, .load_accept, .store_accept
    );

    load_unit load_unit_inst (
        .clk, .reset,
        .entry_valid, .entry, .load_accept,
        .load_valid, .load_ready, .load_tag, .load_result, .load_exc, .load_badvaddr,
        .bus (load_bus)
    );

    store_buffer store_buffer_inst (
        .clk, .reset,
        .entry_valid, .entry, .store_accept,
        .store_valid, .store_tag, .store_exc, .store_badvaddr, .commit_store,
        .bus (store_bus)
    );

    dcache_arbiter dcache_arbiter_inst (
        .clk, .reset,
        .load_bus, .store_bus,
        .dcache_req, .dcache_wr, .dcache_wstrb, .dcache_size, .dcache_addr, .dcache_wdata,
        .dcache_addr_ok, .dcache_data_ok, .dcache_rdata
    );

endmodule

`default_nettype wire

//--- src/store_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module store_buffer (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              entry_valid,
    input  wire lsu_pkg::mem_req_t entry,
    output logic                   store_accept,
    output logic                   store_valid,
    output lsu_pkg::tag_t          store_tag,
    output lsu_pkg::exc_t          store_exc,
    output lsu_pkg::word_t         store_badvaddr,
    input  wire logic              commit_store,
    dbus_if.requester              bus
);

    lsu_pkg::strb_t fifo_strb [lsu_pkg::SB_DEPTH];
    lsu_pkg::size_t fifo_size [lsu_pkg::SB_DEPTH];
    lsu_pkg::word_t fifo_addr [lsu_pkg::SB_DEPTH];
    lsu_pkg::word_t fifo_data [lsu_pkg::SB_DEPTH];

    logic [lsu_pkg::SB_PTR_W-1:0] head;
    logic [lsu_pkg::SB_PTR_W-1:0] tail;
    // entries held, and how many of those from the head are committed
    logic [lsu_pkg::SB_PTR_W:0]   count;
    logic [lsu_pkg::SB_PTR_W:0]   committed;

    logic           sent;
    logic           fault;
    logic           full;
    logic           push;
    logic           drain_done;
    logic           commit_take;
    lsu_pkg::strb_t new_strb;
    lsu_pkg::word_t new_data;

    // byte lanes and replicated data
    always_comb begin
        case (entry.op)
            lsu_pkg::SB: begin
                new_strb = 4'b0001 << entry.addr[1:0];
                new_data = {4{entry.value[7:0]}};
            end
            lsu_pkg::SH: begin
                new_strb = entry.addr[1] ? 4'b1100 : 4'b0011;
                new_data = {2{entry.value[15:0]}};
            end
            default: begin
                new_strb = 4'b1111;
                new_data = entry.value;
            end
        endcase
    end

    assign fault        = lsu_pkg::misaligned(entry.op, entry.addr[1:0]);
    assign full         = count == lsu_pkg::SB_DEPTH;
    assign store_accept = entry_valid && lsu_pkg::is_store(entry.op) && !full;
    assign push         = store_accept && !fault;
    assign drain_done   = sent && bus.data_ok;
    // a stray commit with nothing pending is dropped
    assign commit_take  = commit_store && (committed != count);

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            committed   <= '0;
            sent        <= 1'b0;
            store_valid <= 1'b0;
        end else begin
            store_valid <= store_accept;
            count     <= count + {{lsu_pkg::SB_PTR_W{1'b0}}, push}
                               - {{lsu_pkg::SB_PTR_W{1'b0}}, drain_done};
            committed <= committed + {{lsu_pkg::SB_PTR_W{1'b0}}, commit_take}
                                   - {{lsu_pkg::SB_PTR_W{1'b0}}, drain_done};
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (drain_done) begin
                head <= head + 1'b1;
            end
            if (bus.req && bus.addr_ok) begin
                sent <= 1'b1;
            end else if (drain_done) begin
                sent <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_strb[tail] <= new_strb;
            fifo_size[tail] <= lsu_pkg::access_size(entry.op);
            fifo_addr[tail] <= entry.addr;
            fifo_data[tail] <= new_data;
        end
        if (store_accept) begin
            store_tag      <= entry.tag;
            store_exc      <= fault ? lsu_pkg::EXC_ADES : lsu_pkg::EXC_NONE;
            store_badvaddr <= entry.addr;
        end
    end

    // only a committed head goes out
    assign bus.req   = (committed != '0) && !sent;
    assign bus.wr    = 1'b1;
    assign bus.wstrb = fifo_strb[head];
    assign bus.size  = fifo_size[head];
    assign bus.addr  = fifo_addr[head];
    assign bus.wdata = fifo_data[head];

endmodule

`default_nettype wire

//--- verification/dcache_model.sv
`timescale 1ns/10ps
`default_nettype none

// word memory standing in for the data cache
module dcache_model (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        req,
    input  wire logic        wr,
    input  wire logic [3:0]  wstrb,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wdata,
    output logic             addr_ok,
    output logic             data_ok,
    output logic [31:0]      rdata
);

    logic [31:0] mem [256];
    integer      seed;
    logic        busy;
    logic [7:0]  held_idx;
    int unsigned accept_wait;
    int unsigned reply_wait;

    initial seed = 32'h98051eb3;

    // one transaction at a time and a random wait before each accept
    assign addr_ok = req && !busy && (accept_wait == 0);
    assign data_ok = busy && (reply_wait == 0);
    assign rdata   = data_ok ? mem[held_idx] : 32'h0;

    always @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            accept_wait <= 0;
            reply_wait  <= 0;
        end else begin
            if (addr_ok) begin
                busy        <= 1'b1;
                held_idx    <= addr[9:2];
                reply_wait  <= $unsigned($random(seed)) % 4;
                accept_wait <= $unsigned($random(seed)) % 3;
                if (wr) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wstrb[i]) begin
                            mem[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
                        end
                    end
                end
            end else if (req && !busy && accept_wait != 0) begin
                accept_wait <= accept_wait - 1;
            end
            if (data_ok) begin
                busy <= 1'b0;
            end else if (busy && reply_wait != 0) begin
                reply_wait <= reply_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    localparam int TOTAL_INSTR = 64;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic issue_valid, load_ready, commit_store;
    lsu_pkg::mem_op_t issue_op;
    lsu_pkg::word_t issue_base, issue_value;
    logic [15:0] issue_offset;
    lsu_pkg::tag_t issue_tag;
    logic issue_ready, load_valid, store_valid;
    lsu_pkg::tag_t load_tag, store_tag;
    lsu_pkg::word_t load_result, load_badvaddr, store_badvaddr;
    lsu_pkg::exc_t load_exc, store_exc;
    logic dcache_req, dcache_wr, dcache_addr_ok, dcache_data_ok;
    lsu_pkg::strb_t dcache_wstrb;
    lsu_pkg::size_t dcache_size;
    lsu_pkg::word_t dcache_addr, dcache_wdata, dcache_rdata;

    integer seed = 32'h98051eb3;
    logic random_ready = 1'b0;
    logic reset_q = 1'b1;
    lsu_pkg::tag_t next_tag = '0;
    lsu_pkg::tag_t want_tag;
    lsu_pkg::tag_t store_want;

    // reference state, indexed by tag where possible
    lsu_pkg::word_t exp_result [16];
    lsu_pkg::exc_t  exp_exc [16];
    lsu_pkg::word_t exp_addr [16];
    lsu_pkg::tag_t  load_order[$];
    lsu_pkg::tag_t  store_order[$];
    lsu_pkg::word_t read_addr_exp[$];
    lsu_pkg::size_t read_size_exp[$];
    lsu_pkg::word_t wr_addr_exp[$];
    lsu_pkg::word_t wr_data_exp[$];
    lsu_pkg::strb_t wr_strb_exp[$];
    lsu_pkg::size_t wr_size_exp[$];
    lsu_pkg::word_t ref_mem [256];
    int reads_done = 0, writes_done = 0, commits_done = 0;
    int reads_total = 0, writes_total = 0;

    // previous cycle of the load output for the hold check
    logic held_valid = 1'b0, held_ready = 1'b0;
    lsu_pkg::tag_t held_tag;
    lsu_pkg::word_t held_result;

    always #4 clk = ~clk;

    lsu_top lsu_top_inst (.*);

    dcache_model dcache_model_inst (
        .clk, .reset, .req (dcache_req), .wr (dcache_wr), .wstrb (dcache_wstrb),
        .addr (dcache_addr), .wdata (dcache_wdata),
        .addr_ok (dcache_addr_ok), .data_ok (dcache_data_ok), .rdata (dcache_rdata)
    );

    task automatic stop_on_error(string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        stop_on_error($sformatf("Mismatch at %0t: %s expected %h actual %h",
                                $time, name, expected, actual));
    endtask

    // every byte depends on the full word index
    function automatic lsu_pkg::word_t fill_word(int idx);
        logic [7:0] i;
        i = idx[7:0];
        return {i ^ 8'ha5, i + 8'h17, ~i, i * 8'h3b};
    endfunction

    function automatic logic bad_align(lsu_pkg::mem_op_t op, logic [1:0] low);
        if (op == lsu_pkg::LW || op == lsu_pkg::SW) return low != 2'b00;
        if (op == lsu_pkg::LH || op == lsu_pkg::LHU || op == lsu_pkg::SH) return low[0];
        return 1'b0;
    endfunction

    function automatic lsu_pkg::word_t expect_load(lsu_pkg::mem_op_t op, lsu_pkg::word_t w,
                                                   logic [1:0] low);
        lsu_pkg::word_t s;
        s = w >> (8 * low);
        case (op)
            lsu_pkg::LB:  return {{24{s[7]}}, s[7:0]};
            lsu_pkg::LBU: return {24'h0, s[7:0]};
            lsu_pkg::LH:  return {{16{s[15]}}, s[15:0]};
            lsu_pkg::LHU: return {16'h0, s[15:0]};
            default:      return w;
        endcase
    endfunction

    // record the expected outcome, then hold issue_valid until accepted
    task automatic issue_instr(lsu_pkg::mem_op_t op, lsu_pkg::word_t addr, lsu_pkg::word_t value);
        logic [15:0] off;
        logic fault;
        lsu_pkg::word_t w;
        off = 16'($random(seed));
        fault = bad_align(op, addr[1:0]);
        exp_addr[next_tag] = addr;
        if (op == lsu_pkg::SB || op == lsu_pkg::SH || op == lsu_pkg::SW) begin
            exp_exc[next_tag] = fault ? lsu_pkg::EXC_ADES : lsu_pkg::EXC_NONE;
            store_order.push_back(next_tag);
            if (!fault) begin
                w = ref_mem[addr[9:2]];
                wr_addr_exp.push_back(addr);
                if (op == lsu_pkg::SB) begin
                    wr_strb_exp.push_back(4'b0001 << addr[1:0]);
                    wr_data_exp.push_back({4{value[7:0]}});
                    wr_size_exp.push_back(lsu_pkg::SIZE_BYTE);
                    w[8*addr[1:0] +: 8] = value[7:0];
                end else if (op == lsu_pkg::SH) begin
                    wr_strb_exp.push_back(addr[1] ? 4'b1100 : 4'b0011);
                    wr_data_exp.push_back({2{value[15:0]}});
                    wr_size_exp.push_back(lsu_pkg::SIZE_HALF);
                    w[16*addr[1] +: 16] = value[15:0];
                end else begin
                    wr_strb_exp.push_back(4'b1111);
                    wr_data_exp.push_back(value);
                    wr_size_exp.push_back(lsu_pkg::SIZE_WORD);
                    w = value;
                end
                ref_mem[addr[9:2]] = w;
                writes_total++;
            end
        end else begin
            exp_exc[next_tag] = fault ? lsu_pkg::EXC_ADEL : lsu_pkg::EXC_NONE;
            exp_result[next_tag] = fault ? 32'h0 : expect_load(op, ref_mem[addr[9:2]], addr[1:0]);
            load_order.push_back(next_tag);
            if (!fault) begin
                read_addr_exp.push_back(addr);
                if (op == lsu_pkg::LW) begin
                    read_size_exp.push_back(lsu_pkg::SIZE_WORD);
                end else if (op == lsu_pkg::LH || op == lsu_pkg::LHU) begin
                    read_size_exp.push_back(lsu_pkg::SIZE_HALF);
                end else begin
                    read_size_exp.push_back(lsu_pkg::SIZE_BYTE);
                end
                reads_total++;
            end
        end
        @(posedge clk);
        issue_valid  <= 1'b1;
        issue_op     <= op;
        issue_offset <= off;
        issue_base   <= addr - {{16{off[15]}}, off};
        issue_value  <= value;
        issue_tag    <= next_tag;
        next_tag++;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic commit_and_drain();
        int target;
        target = writes_done + 1;
        @(posedge clk);
        commit_store <= 1'b1;
        @(posedge clk);
        commit_store <= 1'b0;
        while (writes_done < target) @(posedge clk);
    endtask

    task automatic wait_results();
        while (load_order.size() != 0 || store_order.size() != 0) @(posedge clk);
    endtask

    always @(posedge clk) begin
        load_ready <= random_ready ? (($random(seed) & 1) != 0) : 1'b1;
    end

    // load results in issue order and held steady while stalled
    always @(posedge clk) begin
        reset_q <= reset;
        if (reset_q && !reset) begin
            assert (!load_valid && !store_valid && !dcache_req && !issue_ready)
            else stop_on_error("outputs not low in the first cycle after reset");
        end
        if (!reset && held_valid && !held_ready) begin
            assert (load_valid && load_tag == held_tag && load_result == held_result)
            else stop_on_error("stalled load changed or dropped before load_ready");
        end
        held_valid  <= load_valid;
        held_ready  <= load_ready;
        held_tag    <= load_tag;
        held_result <= load_result;
        if (!reset && load_valid) begin
            assert (load_order.size() != 0)
            else stop_on_error("load_valid raised with no load outstanding");
            want_tag = load_order[0];
            assert (load_tag == want_tag) else mismatch("load_tag", want_tag, load_tag);
            assert (load_exc == exp_exc[want_tag])
            else mismatch("load_exc", exp_exc[want_tag], load_exc);
            assert (load_badvaddr == exp_addr[want_tag])
            else mismatch("load_badvaddr", exp_addr[want_tag], load_badvaddr);
            if (exp_exc[want_tag] == lsu_pkg::EXC_NONE) begin
                assert (load_result == exp_result[want_tag])
                else mismatch("load_result", exp_result[want_tag], load_result);
            end
            if (load_ready) void'(load_order.pop_front());
        end
    end

    always @(posedge clk) begin
        if (!reset && store_valid) begin
            assert (store_order.size() != 0)
            else stop_on_error("store_valid raised with no store outstanding");
            store_want = store_order.pop_front();
            assert (store_tag == store_want) else mismatch("store_tag", store_want, store_tag);
            assert (store_exc == exp_exc[store_want])
            else mismatch("store_exc", exp_exc[store_want], store_exc);
            assert (store_badvaddr == exp_addr[store_want])
            else mismatch("store_badvaddr", exp_addr[store_want], store_badvaddr);
        end
    end

    // every accepted dcache transaction against the expected order
    always @(posedge clk) begin
        if (!reset && commit_store) commits_done++;
        if (!reset && dcache_req && dcache_addr_ok) begin
            if (dcache_wr) begin
                assert (commits_done > writes_done)
                else stop_on_error("dcache write issued before its commit");
                assert (wr_addr_exp.size() != 0) else stop_on_error("unexpected dcache write");
                assert (dcache_addr == wr_addr_exp[0])
                else mismatch("dcache_addr", wr_addr_exp[0], dcache_addr);
                assert (dcache_wstrb == wr_strb_exp[0])
                else mismatch("dcache_wstrb", wr_strb_exp[0], dcache_wstrb);
                assert (dcache_size == wr_size_exp[0])
                else mismatch("dcache_size", wr_size_exp[0], dcache_size);
                assert (dcache_wdata == wr_data_exp[0])
                else mismatch("dcache_wdata", wr_data_exp[0], dcache_wdata);
                void'(wr_addr_exp.pop_front());
                void'(wr_strb_exp.pop_front());
                void'(wr_size_exp.pop_front());
                void'(wr_data_exp.pop_front());
                writes_done++;
            end else begin
                assert (read_addr_exp.size() != 0) else stop_on_error("unexpected dcache read");
                assert (dcache_addr == read_addr_exp[0])
                else mismatch("dcache_addr", read_addr_exp[0], dcache_addr);
                assert (dcache_size == read_size_exp[0])
                else mismatch("dcache_size", read_size_exp[0], dcache_size);
                void'(read_addr_exp.pop_front());
                void'(read_size_exp.pop_front());
                reads_done++;
            end
        end
    end

    initial begin
        #(TOTAL_INSTR * 200 * 8);
        stop_on_error("watchdog expired before the tests finished");
    end

    initial begin
        lsu_pkg::mem_op_t op;
        lsu_pkg::word_t addr;
        issue_valid  <= 1'b0;
        issue_op     <= lsu_pkg::LW;
        issue_base   <= '0;
        issue_offset <= '0;
        issue_value  <= '0;
        issue_tag    <= '0;
        load_ready   <= 1'b1;
        commit_store <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
            dcache_model_inst.mem[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // random aligned loads with random back-pressure
        random_ready <= 1'b1;
        repeat (40) begin
            op = lsu_pkg::mem_op_t'($unsigned($random(seed)) % 5);
            addr = {22'h0, 6'($random(seed)), 2'($random(seed))};
            if (op == lsu_pkg::LW) addr[1:0] = 2'b00;
            if (op == lsu_pkg::LH || op == lsu_pkg::LHU) addr[0] = 1'b0;
            issue_instr(op, addr, '0);
        end
        wait_results();
        random_ready <= 1'b0;

        // stores wait for their commit in groups of four
        for (int g = 0; g < 3; g++) begin
            for (int k = 0; k < 4; k++) begin
                op = lsu_pkg::mem_op_t'(5 + (k % 3));
                addr = {22'h0, 1'b1, 7'($random(seed)), 2'($random(seed))};
                if (op == lsu_pkg::SW) addr[1:0] = 2'b00;
                if (op == lsu_pkg::SH) addr[0] = 1'b0;
                issue_instr(op, addr, $random(seed));
            end
            wait_results();
            repeat (20) @(posedge clk);
            repeat (4) commit_and_drain();
        end

        // misaligned accesses fault with no cache traffic
        issue_instr(lsu_pkg::LH, 32'h41, '0);
        issue_instr(lsu_pkg::LHU, 32'h87, '0);
        issue_instr(lsu_pkg::LW, 32'h1a, '0);
        issue_instr(lsu_pkg::LW, 32'h25, '0);
        issue_instr(lsu_pkg::SH, 32'h203, 32'h1234);
        issue_instr(lsu_pkg::SW, 32'h302, 32'h5678);
        wait_results();

        // full buffer plus both queue slots stalls issue
        for (int k = 0; k < 6; k++) begin
            issue_instr(lsu_pkg::SW, 32'h320 + 4 * k, $random(seed));
        end
        repeat (10) begin
            @(negedge clk);
            assert (!issue_ready) else stop_on_error("issue_ready high with the buffer full");
        end
        commit_and_drain();
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        repeat (5) commit_and_drain();
        wait_results();
        repeat (10) @(posedge clk);

        assert (reads_done == reads_total)
        else mismatch("dcache read count", reads_total, reads_done);
        assert (writes_done == writes_total)
        else mismatch("dcache write count", writes_total, writes_done);
        for (int i = 128; i < 256; i++) begin
            assert (dcache_model_inst.mem[i] == ref_mem[i])
            else mismatch($sformatf("mem[%0d]", i), ref_mem[i], dcache_model_inst.mem[i]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/lsu_pkg.sv
src/dbus_if.sv
src/agu_issue_queue.sv
src/load_unit.sv
src/store_buffer.sv
src/dcache_arbiter.sv
src/lsu_top.sv
verification/dcache_model.sv
verification/lsu_tb.sv
